//--- files.f
+incdir+include
source/periph_pkg.sv
source/sync_wedge.sv
source/apb_periph_decoder.sv
source/gpio_regs.sv
source/ref_timer.sv
source/watchdog.sv
source/soc_periph_top.sv
testbench/tb_soc_periph.sv

//--- Makefile
TOP := tb_soc_periph

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Simulator exit status nonzero: Testbench failed" >> sim.log
	cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_soc_periph.sv
`timescale 1ns/1ps
`include "periph_consts.svh"

module tb_soc_periph;

    // About 1000 cycles of tests, generous margin for the run limit
    localparam int TIMEOUT_CYCLES = 20000;
    // Cycles waited after each kick, the next kick lands 25 cycles after the last
    localparam int KICK_WAIT = 23;

    logic                   clk_i = 1'b0;
    logic                   rst_n_i;
    logic                   slow_clk_i;
    periph_pkg::apb_req_t   apb_req;
    periph_pkg::apb_resp_t  apb_resp_o;
    periph_pkg::gpio_vec_t  gpio_in_i;
    periph_pkg::gpio_vec_t  gpio_out_o;
    periph_pkg::gpio_vec_t  gpio_dir_o;
    logic                   dma_pe_evt_i;
    logic                   dma_pe_irq_i;
    logic                   pf_evt_i;
    periph_pkg::fc_events_t fc_events_o;
    logic                   wdt_reset_o;

    logic [15:0] lfsr_state;
    logic        count_en;
    int          gpio_cnt;
    int          lo_cnt;
    int          hi_cnt;
    int          edge_cnt;

    soc_periph_top dut (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .slow_clk_i   ( slow_clk_i   ),
        .apb_req_i    ( apb_req      ),
        .apb_resp_o   ( apb_resp_o   ),
        .gpio_in_i    ( gpio_in_i    ),
        .gpio_out_o   ( gpio_out_o   ),
        .gpio_dir_o   ( gpio_dir_o   ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .fc_events_o  ( fc_events_o  ),
        .wdt_reset_o  ( wdt_reset_o  )
    );

    always #4 clk_i = ~clk_i;

    ////////////////////////////////////////
    // Reporting and random numbers
    ////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s at %0t", msg, $time);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // Fibonacci LFSR with taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////
    // Reference models
    ////////////////////////////////////////

    function automatic logic [31:0] reg_addr(input logic [1:0] slot, input logic [7:0] ofs);
        logic [31:0] a;
        a = '0;
        a[`PERIPH_SEL_LSB +: `PERIPH_SEL_W] = slot;
        a[7:0] = ofs;
        return a;
    endfunction

    // Inputs start from all zero, so every set pin is a rise
    function automatic logic [31:0] gpio_status_model(input logic [31:0] pattern,
                                                      input logic [31:0] inten);
        return pattern & inten;
    endfunction

    // Steps the tick rule, returns the final count
    function automatic int timer_model(input int ticks, input int cmp_lo, input int cmp_hi,
                                       input int start, output int n_lo, output int n_hi);
        int cnt;
        cnt  = start;
        n_lo = 0;
        n_hi = 0;
        for (int t = 0; t < ticks; t++) begin
            if (cnt == cmp_hi) begin
                cnt = 0;
                n_hi++;
            end else begin
                cnt++;
                if (cnt == cmp_lo) n_lo++;
            end
        end
        return cnt;
    endfunction

    ////////////////////////////////////////
    // APB transfers and reset
    ////////////////////////////////////////

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        apb_req.pwrite  <= 1'b1;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge clk_i);
        apb_req.penable <= 1'b1;
        @(posedge clk_i);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk_i);
        apb_req.paddr   <= addr;
        apb_req.pwrite  <= 1'b0;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge clk_i);
        apb_req.penable <= 1'b1;
        // Zero wait states, response is valid within the access cycle
        @(negedge clk_i);
        check_eq("apb_resp_o.pready", 32'd1, apb_resp_o.pready);
        data = apb_resp_o.prdata;
        err  = apb_resp_o.pslverr;
        @(posedge clk_i);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_eq("apb_resp_o.pslverr", 32'd0, err);
        check_eq(name, exp, data);
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        rst_n_i <= 1'b0;
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
    endtask

    task automatic clear_counters();
        gpio_cnt = 0;
        lo_cnt   = 0;
        hi_cnt   = 0;
        edge_cnt = 0;
    endtask

    ////////////////////////////////////////
    // Checker and event counting
    ////////////////////////////////////////

    always @(negedge clk_i) begin
        check_eq("fc_events_o.dma_evt", dma_pe_evt_i, fc_events_o.dma_evt);
        check_eq("fc_events_o.dma_irq", dma_pe_irq_i, fc_events_o.dma_irq);
        check_eq("fc_events_o.pf", pf_evt_i, fc_events_o.pf);
        check_eq("fc_events_o.reserved_hi", 32'd0, fc_events_o.reserved_hi);
        check_eq("fc_events_o.reserved_13", 32'd0, fc_events_o.reserved_13);
        check_eq("fc_events_o.sw_reserved", 32'd0, fc_events_o.sw_reserved);
        if (count_en) begin
            gpio_cnt += int'(fc_events_o.gpio);
            lo_cnt   += int'(fc_events_o.timer_lo);
            hi_cnt   += int'(fc_events_o.timer_hi);
            edge_cnt += int'(fc_events_o.ref_edge);
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        report_failure("Timeout, the tests did not finish");
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] dir_val;
        logic [31:0] out_val;
        logic [31:0] rnd;
        logic [31:0] pattern;
        logic [31:0] inten_val;
        logic [31:0] exp_status;
        logic [31:0] rd_data;
        logic        rd_err;
        int          n;
        int          exp_lo;
        int          exp_hi;
        int          exp_final;

        rst_n_i      = 1'b0;
        slow_clk_i   = 1'b0;
        apb_req      = '0;
        gpio_in_i    = '0;
        dma_pe_evt_i = 1'b0;
        dma_pe_irq_i = 1'b0;
        pf_evt_i     = 1'b0;
        count_en     = 1'b0;
        lfsr_state   = 16'd10011;
        clear_counters();

        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_eq("fc_events_o", 32'd0, fc_events_o);
        check_eq("wdt_reset_o", 32'd0, wdt_reset_o);
        check_eq("gpio_dir_o", 32'd0, gpio_dir_o);
        check_eq("gpio_out_o", 32'd0, gpio_out_o);

        // GPIO registers
        draw_bits(32, dir_val);
        draw_bits(32, out_val);
        apb_write(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_DIR_OFS), dir_val);
        apb_write(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_OUT_OFS), out_val);
        read_check(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_DIR_OFS), dir_val, "gpio DIR");
        read_check(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_OUT_OFS), out_val, "gpio OUT");
        @(negedge clk_i);
        check_eq("gpio_dir_o", dir_val, gpio_dir_o);
        check_eq("gpio_out_o", out_val, gpio_out_o);
        draw_bits(32, rnd);
        @(posedge clk_i);
        gpio_in_i <= rnd;
        repeat (4) @(posedge clk_i);
        read_check(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_IN_OFS), rnd, "gpio IN");

        // GPIO interrupt, the second pass masks every rising pin
        for (int iter = 0; iter < 2; iter++) begin
            @(posedge clk_i);
            gpio_in_i <= '0;
            repeat (4) @(posedge clk_i);
            draw_bits(32, pattern);
            draw_bits(32, inten_val);
            if (iter == 1) inten_val = ~pattern;
            apb_write(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_INTEN_OFS), inten_val);
            apb_write(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_STATUS_OFS), 32'hFFFF_FFFF);
            clear_counters();
            count_en = 1'b1;
            @(posedge clk_i);
            gpio_in_i <= pattern;
            repeat (4) @(posedge clk_i);
            count_en = 1'b0;
            exp_status = gpio_status_model(pattern, inten_val);
            check_eq("fc_events_o.gpio pulses", (exp_status != 0) ? 32'd1 : 32'd0, gpio_cnt);
            read_check(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_STATUS_OFS), exp_status,
                       "gpio STATUS");
            apb_write(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_STATUS_OFS), 32'hFFFF_FFFF);
            read_check(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_STATUS_OFS), 32'd0,
                       "gpio STATUS after clear");
        end

        // Reference timer, slow clock toggles every 6 cycles
        apb_write(reg_addr(`PERIPH_SLOT_TIMER, `TMR_CMP_LO_OFS), 32'd3);
        apb_write(reg_addr(`PERIPH_SLOT_TIMER, `TMR_CMP_HI_OFS), 32'd5);
        apb_write(reg_addr(`PERIPH_SLOT_TIMER, `TMR_COUNT_OFS), 32'd0);
        apb_write(reg_addr(`PERIPH_SLOT_TIMER, `TMR_CTRL_OFS), 32'd1);
        clear_counters();
        count_en = 1'b1;
        repeat (18) begin
            repeat (6) @(posedge clk_i);
            slow_clk_i <= 1'b1;
            repeat (6) @(posedge clk_i);
            slow_clk_i <= 1'b0;
        end
        repeat (6) @(posedge clk_i);
        count_en = 1'b0;
        exp_final = timer_model(18, 3, 5, 0, exp_lo, exp_hi);
        check_eq("fc_events_o.timer_lo pulses", exp_lo, lo_cnt);
        check_eq("fc_events_o.timer_hi pulses", exp_hi, hi_cnt);
        assert (edge_cnt >= 35 && edge_cnt <= 37) else begin
            $display("[FAIL] %0t fc_events_o.ref_edge pulses expected 36 +-1 actual %0d",
                     $time, edge_cnt);
            $display("Testbench failed");
            $fatal(1);
        end
        read_check(reg_addr(`PERIPH_SLOT_TIMER, `TMR_COUNT_OFS), exp_final, "timer COUNT");
        apb_write(reg_addr(`PERIPH_SLOT_TIMER, `TMR_CTRL_OFS), 32'd0);

        // Watchdog kicked every 25 cycles for 200 cycles
        apb_write(reg_addr(`PERIPH_SLOT_WDT, `WDT_LOAD_OFS), 32'd40);
        apb_write(reg_addr(`PERIPH_SLOT_WDT, `WDT_CTRL_OFS), 32'd1);
        repeat (8) begin
            apb_write(reg_addr(`PERIPH_SLOT_WDT, `WDT_KICK_OFS), `WDT_KICK_KEY);
            repeat (KICK_WAIT) begin
                @(negedge clk_i);
                check_eq("wdt_reset_o", 32'd0, wdt_reset_o);
            end
        end
        // Cycles since the last kick, counting the ones already checked
        n = KICK_WAIT;
        do begin
            @(negedge clk_i);
            n++;
        end while (!wdt_reset_o && n < 60);
        assert (wdt_reset_o && n >= 36 && n <= 44)
            else report_failure("Watchdog reset did not rise 36 to 44 cycles after the kick");

        // A wrong key must fire the watchdog at once
        apply_reset();
        @(negedge clk_i);
        check_eq("wdt_reset_o", 32'd0, wdt_reset_o);
        apb_write(reg_addr(`PERIPH_SLOT_WDT, `WDT_LOAD_OFS), 32'd40);
        apb_write(reg_addr(`PERIPH_SLOT_WDT, `WDT_CTRL_OFS), 32'd1);
        apb_write(reg_addr(`PERIPH_SLOT_WDT, `WDT_KICK_OFS), `WDT_KICK_KEY ^ 32'd1);
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!wdt_reset_o && n < 2);
        assert (wdt_reset_o) else report_failure("Wrong kick key did not assert wdt_reset_o");

        // Pass-through events, compared by the checker every cycle
        repeat (16) begin
            draw_bits(3, rnd);
            @(posedge clk_i);
            dma_pe_evt_i <= rnd[0];
            dma_pe_irq_i <= rnd[1];
            pf_evt_i     <= rnd[2];
        end
        @(posedge clk_i);
        dma_pe_evt_i <= 1'b0;
        dma_pe_irq_i <= 1'b0;
        pf_evt_i     <= 1'b0;

        // Unmapped slot
        apb_read(reg_addr(2'd3, 8'h00), rd_data, rd_err);
        check_eq("apb_resp_o.pslverr", 32'd1, rd_err);
        check_eq("apb_resp_o.prdata", 32'd0, rd_data);

        repeat (4) @(posedge clk_i);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- source/soc_periph_top.sv
`timescale 1ns/1ps

module soc_periph_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   slow_clk_i,
    input  periph_pkg::apb_req_t   apb_req_i,
    output periph_pkg::apb_resp_t  apb_resp_o,
    input  periph_pkg::gpio_vec_t  gpio_in_i,
    output periph_pkg::gpio_vec_t  gpio_out_o,
    output periph_pkg::gpio_vec_t  gpio_dir_o,
    input  logic                   dma_pe_evt_i,
    input  logic                   dma_pe_irq_i,
    input  logic                   pf_evt_i,
    output periph_pkg::fc_events_t fc_events_o,
    output logic                   wdt_reset_o
);

    periph_pkg::apb_req_t  gpio_req;
    periph_pkg::apb_req_t  tmr_req;
    periph_pkg::apb_req_t  wdt_req;
    periph_pkg::apb_resp_t gpio_resp;
    periph_pkg::apb_resp_t tmr_resp;
    periph_pkg::apb_resp_t wdt_resp;
    logic                  gpio_event;
    logic                  ref_rise;
    logic                  ref_fall;
    logic                  timer_lo;
    logic                  timer_hi;

    ////////////////////////////////////////
    // APB decode
    ////////////////////////////////////////

    apb_periph_decoder i_decoder (
        .clk_i       ( clk_i      ),
        .rst_n_i     ( rst_n_i    ),
        .apb_req_i   ( apb_req_i  ),
        .apb_resp_o  ( apb_resp_o ),
        .gpio_req_o  ( gpio_req   ),
        .tmr_req_o   ( tmr_req    ),
        .wdt_req_o   ( wdt_req    ),
        .gpio_resp_i ( gpio_resp  ),
        .tmr_resp_i  ( tmr_resp   ),
        .wdt_resp_i  ( wdt_resp   )
    );

    ////////////////////////////////////////
    // Slaves
    ////////////////////////////////////////

    gpio_regs i_gpio (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .apb_req_i  ( gpio_req   ),
        .apb_resp_o ( gpio_resp  ),
        .gpio_in_i  ( gpio_in_i  ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .event_o    ( gpio_event )
    );

    // Slow clock sampled as data in the fast domain
    sync_wedge i_ref_sync (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .data_i  ( slow_clk_i ),
        .rise_o  ( ref_rise   ),
        .fall_o  ( ref_fall   )
    );

    ref_timer i_timer (
        .clk_i      ( clk_i    ),
        .rst_n_i    ( rst_n_i  ),
        .apb_req_i  ( tmr_req  ),
        .apb_resp_o ( tmr_resp ),
        .tick_i     ( ref_rise ),
        .irq_lo_o   ( timer_lo ),
        .irq_hi_o   ( timer_hi )
    );

    watchdog i_wdt (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .apb_req_i   ( wdt_req     ),
        .apb_resp_o  ( wdt_resp    ),
        .wdt_reset_o ( wdt_reset_o )
    );

    ////////////////////////////////////////
    // Event vector
    ////////////////////////////////////////

    always_comb begin
        fc_events_o          = '0;
        fc_events_o.dma_evt  = dma_pe_evt_i;
        fc_events_o.dma_irq  = dma_pe_irq_i;
        fc_events_o.timer_lo = timer_lo;
        fc_events_o.timer_hi = timer_hi;
        fc_events_o.pf       = pf_evt_i;
        fc_events_o.ref_edge = ref_rise | ref_fall;
        fc_events_o.gpio     = gpio_event;
    end

endmodule

//--- source/watchdog.sv
`timescale 1ns/1ps
`include "periph_consts.svh"

module watchdog (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  periph_pkg::apb_req_t  apb_req_i,
    output periph_pkg::apb_resp_t apb_resp_o,
    output logic                  wdt_reset_o
);

    logic                      en_q;
    logic [`PERIPH_DATA_W-1:0] load_q;
    logic [`PERIPH_DATA_W-1:0] count_q;
    logic                      wr_en;
    logic [7:0]                ofs;

    assign wr_en = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
    assign ofs   = apb_req_i.paddr[7:0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q        <= 1'b0;
            load_q      <= '0;
            count_q     <= '0;
            wdt_reset_o <= 1'b0;
        end else begin
            // Free running countdown while armed
            if (en_q) begin
                if (count_q == '0) wdt_reset_o <= 1'b1;
                else               count_q     <= count_q - 1'b1;
            end
            if (wr_en) begin
                case (ofs)
                    `WDT_CTRL_OFS: begin
                        en_q <= apb_req_i.pwdata[0];
                        if (apb_req_i.pwdata[0]) count_q <= load_q;
                    end
                    `WDT_LOAD_OFS: load_q <= apb_req_i.pwdata;
                    `WDT_KICK_OFS: begin
                        // A wrong key is treated as a runaway program
                        if (apb_req_i.pwdata == `WDT_KICK_KEY) count_q     <= load_q;
                        else                                  wdt_reset_o <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (ofs)
            `WDT_CTRL_OFS:  apb_resp_o.prdata = {{(`PERIPH_DATA_W-1){1'b0}}, en_q};
            `WDT_LOAD_OFS:  apb_resp_o.prdata = load_q;
            `WDT_COUNT_OFS: apb_resp_o.prdata = count_q;
            default:        apb_resp_o.prdata = '0;
        endcase
        apb_resp_o.pready  = 1'b1;
        apb_resp_o.pslverr = 1'b0;
    end

    a_reset_sticky : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wdt_reset_o |=> wdt_reset_o
    );

endmodule

//--- source/ref_timer.sv
`timescale 1ns/1ps
`include "periph_consts.svh"

module ref_timer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  periph_pkg::apb_req_t  apb_req_i,
    output periph_pkg::apb_resp_t apb_resp_o,
    input  logic                  tick_i,
    output logic                  irq_lo_o,
    output logic                  irq_hi_o
);

    logic                      en_q;
    logic [`PERIPH_DATA_W-1:0] count_q;
    logic [`PERIPH_DATA_W-1:0] count_inc;
    logic [`PERIPH_DATA_W-1:0] cmp_lo_q;
    logic [`PERIPH_DATA_W-1:0] cmp_hi_q;
    logic                      wr_en;
    logic [7:0]                ofs;

    assign wr_en     = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
    assign ofs       = apb_req_i.paddr[7:0];
    assign count_inc = count_q + 1'b1;

    ////////////////////////////////////////
    // Counter and compare
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q     <= 1'b0;
            count_q  <= '0;
            cmp_lo_q <= '0;
            cmp_hi_q <= '0;
            irq_lo_o <= 1'b0;
            irq_hi_o <= 1'b0;
        end else begin
            irq_lo_o <= 1'b0;
            irq_hi_o <= 1'b0;
            if (en_q && tick_i) begin
                if (count_q == cmp_hi_q) begin
                    // High compare reloads from zero
                    count_q  <= '0;
                    irq_hi_o <= 1'b1;
                end else begin
                    count_q  <= count_inc;
                    irq_lo_o <= (count_inc == cmp_lo_q);
                end
            end
            // Bus writes take priority over a tick
            if (wr_en) begin
                case (ofs)
                    `TMR_CTRL_OFS:   en_q     <= apb_req_i.pwdata[0];
                    `TMR_COUNT_OFS:  count_q  <= apb_req_i.pwdata;
                    `TMR_CMP_LO_OFS: cmp_lo_q <= apb_req_i.pwdata;
                    `TMR_CMP_HI_OFS: cmp_hi_q <= apb_req_i.pwdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (ofs)
            `TMR_CTRL_OFS:   apb_resp_o.prdata = {{(`PERIPH_DATA_W-1){1'b0}}, en_q};
            `TMR_COUNT_OFS:  apb_resp_o.prdata = count_q;
            `TMR_CMP_LO_OFS: apb_resp_o.prdata = cmp_lo_q;
            `TMR_CMP_HI_OFS: apb_resp_o.prdata = cmp_hi_q;
            default:         apb_resp_o.prdata = '0;
        endcase
        apb_resp_o.pready  = 1'b1;
        apb_resp_o.pslverr = 1'b0;
    end

    a_irq_exclusive : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(irq_lo_o && irq_hi_o)
    );

endmodule

//--- source/gpio_regs.sv
`timescale 1ns/1ps
`include "periph_consts.svh"

module gpio_regs (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  periph_pkg::apb_req_t  apb_req_i,
    output periph_pkg::apb_resp_t apb_resp_o,
    input  periph_pkg::gpio_vec_t gpio_in_i,
    output periph_pkg::gpio_vec_t gpio_out_o,
    output periph_pkg::gpio_vec_t gpio_dir_o,
    output logic                  event_o
);

    periph_pkg::gpio_vec_t dir_q;
    periph_pkg::gpio_vec_t out_q;
    periph_pkg::gpio_vec_t inten_q;
    periph_pkg::gpio_vec_t status_q;
    periph_pkg::gpio_vec_t in_rise;
    periph_pkg::gpio_vec_t in_fall;
    periph_pkg::gpio_vec_t in_level_q;
    periph_pkg::gpio_vec_t in_sync;
    periph_pkg::gpio_vec_t irq_set;
    logic                  wr_en;
    logic [7:0]            ofs;

    ////////////////////////////////////////
    // Input capture
    ////////////////////////////////////////

    sync_wedge #(
        .T ( periph_pkg::gpio_vec_t )
    ) i_in_sync (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .data_i  ( gpio_in_i ),
        .rise_o  ( in_rise   ),
        .fall_o  ( in_fall   )
    );

    // Level rebuilt from the edges, equals the second sync stage
    assign in_sync = (in_level_q | in_rise) & ~in_fall;
    assign irq_set = in_rise & inten_q;
    assign event_o = |irq_set;

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////

    assign wr_en = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
    assign ofs   = apb_req_i.paddr[7:0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dir_q      <= '0;
            out_q      <= '0;
            inten_q    <= '0;
            status_q   <= '0;
            in_level_q <= '0;
        end else begin
            in_level_q <= in_sync;
            status_q   <= status_q | irq_set;
            if (wr_en) begin
                case (ofs)
                    `GPIO_DIR_OFS:   dir_q   <= apb_req_i.pwdata;
                    `GPIO_OUT_OFS:   out_q   <= apb_req_i.pwdata;
                    `GPIO_INTEN_OFS: inten_q <= apb_req_i.pwdata;
                    // Write one to clear, a new event still sets its bit
                    `GPIO_STATUS_OFS: status_q <= (status_q & ~apb_req_i.pwdata) | irq_set;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (ofs)
            `GPIO_DIR_OFS:    apb_resp_o.prdata = dir_q;
            `GPIO_OUT_OFS:    apb_resp_o.prdata = out_q;
            `GPIO_IN_OFS:     apb_resp_o.prdata = in_sync;
            `GPIO_INTEN_OFS:  apb_resp_o.prdata = inten_q;
            `GPIO_STATUS_OFS: apb_resp_o.prdata = status_q;
            default:          apb_resp_o.prdata = '0;
        endcase
        apb_resp_o.pready  = 1'b1;
        apb_resp_o.pslverr = 1'b0;
    end

    assign gpio_dir_o = dir_q;
    assign gpio_out_o = out_q;

endmodule

//--- source/apb_periph_decoder.sv
`timescale 1ns/1ps
`include "periph_consts.svh"

module apb_periph_decoder (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  periph_pkg::apb_req_t  apb_req_i,
    output periph_pkg::apb_resp_t apb_resp_o,
    output periph_pkg::apb_req_t  gpio_req_o,
    output periph_pkg::apb_req_t  tmr_req_o,
    output periph_pkg::apb_req_t  wdt_req_o,
    input  periph_pkg::apb_resp_t gpio_resp_i,
    input  periph_pkg::apb_resp_t tmr_resp_i,
    input  periph_pkg::apb_resp_t wdt_resp_i
);

    logic [`PERIPH_SEL_W-1:0] slot;

    assign slot = apb_req_i.paddr[`PERIPH_SEL_LSB +: `PERIPH_SEL_W];

    ////////////////////////////////////////
    // Request fan-out
    ////////////////////////////////////////

    // All fields are shared, only psel is steered
    always_comb begin
        gpio_req_o      = apb_req_i;
        tmr_req_o       = apb_req_i;
        wdt_req_o       = apb_req_i;
        gpio_req_o.psel = apb_req_i.psel && (slot == `PERIPH_SLOT_GPIO);
        tmr_req_o.psel  = apb_req_i.psel && (slot == `PERIPH_SLOT_TIMER);
        wdt_req_o.psel  = apb_req_i.psel && (slot == `PERIPH_SLOT_WDT);
    end

    ////////////////////////////////////////
    // Response mux
    ////////////////////////////////////////

    always_comb begin
        case (slot)
            `PERIPH_SLOT_GPIO:  apb_resp_o = gpio_resp_i;
            `PERIPH_SLOT_TIMER: apb_resp_o = tmr_resp_i;
            `PERIPH_SLOT_WDT:   apb_resp_o = wdt_resp_i;
            default: begin
                // Nothing mapped here, complete at once with an error
                apb_resp_o.prdata  = '0;
                apb_resp_o.pready  = 1'b1;
                apb_resp_o.pslverr = 1'b1;
            end
        endcase
    end

    a_one_slave_selected : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({gpio_req_o.psel, tmr_req_o.psel, wdt_req_o.psel})
    );

endmodule

//--- source/sync_wedge.sv
`timescale 1ns/1ps

module sync_wedge #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  T     data_i,
    output T     rise_o,
    output T     fall_o
);

    // Two metastability stages followed by a delay stage
    T sync_q1;
    T sync_q2;
    T dly_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            dly_q   <= '0;
        end else begin
            sync_q1 <= data_i;
            sync_q2 <= sync_q1;
            dly_q   <= sync_q2;
        end
    end

    // Edges seen between second stage and delay stage
    assign rise_o = sync_q2 & ~dly_q;
    assign fall_o = ~sync_q2 & dly_q;

    a_no_shared_edge : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rise_o & fall_o) == '0
    );

endmodule

//--- source/periph_pkg.sv
`include "periph_consts.svh"

package periph_pkg;

    // APB request from the master side
    typedef struct packed {
        logic [`PERIPH_ADDR_W-1:0] paddr;
        logic [`PERIPH_DATA_W-1:0] pwdata;
        logic                      pwrite;
        logic                      psel;
        logic                      penable;
    } apb_req_t;

    // APB response from a slave
    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_resp_t;

    // One bit per pin
    typedef logic [`PERIPH_NGPIO-1:0] gpio_vec_t;

    // Fabric controller event lines, MSB first
    typedef struct packed {
        logic [15:0] reserved_hi;
        logic        gpio;
        logic        ref_edge;
        logic        reserved_13;
        logic        pf;
        logic        timer_hi;
        logic        timer_lo;
        logic        dma_irq;
        logic        dma_evt;
        logic [7:0]  sw_reserved;
    } fc_events_t;

endpackage

//--- include/periph_consts.svh
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Bus and pin widths
`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32
`define PERIPH_NGPIO  32

// Slave select field in paddr
`define PERIPH_SEL_LSB 12
`define PERIPH_SEL_W   2

// Slot numbers, slot 3 stays unmapped
`define PERIPH_SLOT_GPIO  2'd0
`define PERIPH_SLOT_TIMER 2'd1
`define PERIPH_SLOT_WDT   2'd2

// GPIO register offsets
`define GPIO_DIR_OFS    8'h00
`define GPIO_OUT_OFS    8'h04
`define GPIO_IN_OFS     8'h08
`define GPIO_INTEN_OFS  8'h0C
`define GPIO_STATUS_OFS 8'h10

// Timer register offsets
`define TMR_CTRL_OFS   8'h00
`define TMR_COUNT_OFS  8'h04
`define TMR_CMP_LO_OFS 8'h08
`define TMR_CMP_HI_OFS 8'h0C

// Watchdog register offsets and reload key
`define WDT_CTRL_OFS  8'h00
`define WDT_LOAD_OFS  8'h04
`define WDT_KICK_OFS  8'h08
`define WDT_COUNT_OFS 8'h0C
`define WDT_KICK_KEY  32'h5A5A_0001

`endif
